// File: source/conn_mgr_settings.svh
`ifndef CONN_MGR_SETTINGS_SVH
`define CONN_MGR_SETTINGS_SVH

// Width of the UDP payload stream coming from the UDP stack
`define CM_DATA_WIDTH 256

// One keep bit per byte lane
`define CM_KEEP_WIDTH (`CM_DATA_WIDTH / 8)

// The connection request is a fixed 64-byte message
`define CM_MSG_BYTES 64

`define CM_MSG_BEATS ((`CM_MSG_BYTES + `CM_KEEP_WIDTH - 1) / `CM_KEEP_WIDTH) // Beats per message

`define CM_UDP_HDR_BYTES 8 // Counted in the UDP length field

// Port the connection manager listens on
`define CM_LISTEN_PORT 16'h4321

`endif

// File: source/conn_mgr_pkg.sv
`include "conn_mgr_settings.svh"

package conn_mgr_pkg;

    typedef logic [15:0] udp_port_t; // Also used for the UDP length field
    typedef logic [6:0]  req_type_t;
    typedef logic [23:0] qpn_t;
    typedef logic [23:0] psn_t;
    typedef logic [31:0] r_key_t;
    typedef logic [63:0] vaddr_t;
    typedef logic [31:0] ipv4_addr_t;

    // Byte n of the message sits at bits 8n upward
    typedef logic [`CM_MSG_BYTES*8-1:0] qp_msg_t;

    typedef struct packed {
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_port_t length;
        udp_port_t checksum;
    } udp_hdr_t;

    typedef struct packed {
        logic [`CM_DATA_WIDTH-1:0] data;
        logic [`CM_KEEP_WIDTH-1:0] keep;
        logic                      last;
        logic                      user; // Error flag from the UDP stack
    } payload_beat_t;

    // Decoded queue-pair record, local side then remote side
    typedef struct packed {
        req_type_t  req_type;
        qpn_t       loc_qpn;
        psn_t       loc_psn;
        r_key_t     loc_r_key;
        vaddr_t     loc_base_addr;
        ipv4_addr_t loc_ip_addr;
        qpn_t       rem_qpn;
        psn_t       rem_psn;
        r_key_t     rem_r_key;
        vaddr_t     rem_base_addr;
        ipv4_addr_t rem_ip_addr;
        udp_port_t  listening_port;
    } qp_info_t;

    typedef enum logic [1:0] {
        IDLE,    // Waiting for a UDP header
        COLLECT, // Forwarding payload of an accepted frame
        DISCARD  // Draining payload of a rejected frame
    } frame_state_e;

endpackage

// File: source/udp_frame_filter.sv
`timescale 1ns/1ps
`include "conn_mgr_settings.svh"

module udp_frame_filter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        hdr_valid,
    output logic                        hdr_ready,
    input  conn_mgr_pkg::udp_hdr_t      hdr,
    input  logic                        payload_valid,
    output logic                        payload_ready,
    input  conn_mgr_pkg::payload_beat_t payload,
    output logic                        beat_valid,
    input  logic                        beat_ready,
    output conn_mgr_pkg::payload_beat_t beat,
    output logic                        busy
);

    // UDP length covers the 8 header bytes as well as the message
    localparam conn_mgr_pkg::udp_port_t FRAME_LENGTH =
        conn_mgr_pkg::udp_port_t'(`CM_UDP_HDR_BYTES + `CM_MSG_BYTES);

    conn_mgr_pkg::frame_state_e state;
    conn_mgr_pkg::frame_state_e state_next;

    logic hdr_match;
    logic hdr_xfer;
    logic payload_xfer;

    assign hdr_match = (hdr.dest_port == `CM_LISTEN_PORT) && (hdr.length == FRAME_LENGTH);

    assign hdr_xfer     = hdr_valid && hdr_ready;
    assign payload_xfer = payload_valid && payload_ready;

    always_comb begin
        state_next = state;
        case (state)
            conn_mgr_pkg::IDLE: begin
                if (hdr_xfer) begin
                    state_next = hdr_match ? conn_mgr_pkg::COLLECT : conn_mgr_pkg::DISCARD;
                end
            end
            conn_mgr_pkg::COLLECT,
            conn_mgr_pkg::DISCARD: begin
                if (payload_xfer && payload.last) begin
                    state_next = conn_mgr_pkg::IDLE; // Frame ends with its last beat
                end
            end
            default: begin
                state_next = conn_mgr_pkg::IDLE;
            end
        endcase
    end

    // Accepted frames go straight through, so back-pressure reaches upstream
    always_comb begin
        case (state)
            conn_mgr_pkg::COLLECT: payload_ready = beat_ready;
            conn_mgr_pkg::DISCARD: payload_ready = 1'b1; // Drop everything until last
            default:               payload_ready = 1'b0;
        endcase
    end

    assign beat_valid = payload_valid && (state == conn_mgr_pkg::COLLECT);
    assign beat       = payload;

    assign busy = (state != conn_mgr_pkg::IDLE);

    // Header ready is registered and follows the next state, low while in reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= conn_mgr_pkg::IDLE;
            hdr_ready <= 1'b0;
        end else begin
            state     <= state_next;
            hdr_ready <= (state_next == conn_mgr_pkg::IDLE);
        end
    end

endmodule

// File: source/qp_msg_assembler.sv
`timescale 1ns/1ps
`include "conn_mgr_settings.svh"

module qp_msg_assembler (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        beat_valid,
    output logic                        beat_ready,
    input  conn_mgr_pkg::payload_beat_t beat,
    output logic                        msg_valid,
    input  logic                        msg_ready,
    output conn_mgr_pkg::qp_msg_t       msg
);

    // Counter saturates at CM_MSG_BEATS, which flags a frame that is too long
    localparam int CNT_W  = $clog2(`CM_MSG_BEATS + 1);
    localparam int LANE_W = `CM_DATA_WIDTH;

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CM_MSG_BEATS - 1);
    localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(`CM_MSG_BEATS);

    logic [CNT_W-1:0]          beat_cnt;
    logic                      user_seen;
    logic [`CM_DATA_WIDTH-1:0] lane_data;
    logic                      beat_xfer;
    logic                      msg_good;

    // No room for a new frame while a finished message waits downstream
    assign beat_ready = !msg_valid;
    assign beat_xfer  = beat_valid && beat_ready;

    // Bytes without their keep bit are stored as zero
    always_comb begin
        for (int i = 0; i < `CM_KEEP_WIDTH; i++) begin
            lane_data[i*8 +: 8] = beat.keep[i] ? beat.data[i*8 +: 8] : 8'h00;
        end
    end

    // A last beat at any other count means the frame was short or long,
    // which also covers a last flag seen before the final lane
    assign msg_good = (beat_cnt == CNT_LAST) && !user_seen && !beat.user;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt  <= '0;
            user_seen <= 1'b0;
            msg_valid <= 1'b0;
        end else begin
            if (msg_valid && msg_ready) begin
                msg_valid <= 1'b0;
            end
            if (beat_xfer) begin
                if (beat.last) begin
                    beat_cnt  <= '0;
                    user_seen <= 1'b0;
                    msg_valid <= msg_good; // Bad messages vanish here
                end else begin
                    if (beat_cnt != CNT_MAX) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    user_seen <= user_seen || beat.user;
                end
            end
        end
    end

    // Message buffer, one lane per beat
    always_ff @(posedge clk) begin
        if (beat_xfer && (beat_cnt < CNT_MAX)) begin
            msg[beat_cnt*LANE_W +: LANE_W] <= lane_data;
        end
    end

endmodule

// File: source/qp_info_unpack.sv
`timescale 1ns/1ps

module qp_info_unpack (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   msg_valid,
    output logic                   msg_ready,
    input  conn_mgr_pkg::qp_msg_t  msg,
    output logic                   qp_info_valid,
    input  logic                   qp_info_ready,
    output conn_mgr_pkg::qp_info_t qp_info
);

    // Byte offsets of each field inside the message
    localparam int LOC_QPN_B   = 1;
    localparam int LOC_PSN_B   = 5;
    localparam int LOC_RKEY_B  = 9;
    localparam int LOC_ADDR_B  = 13;
    localparam int LOC_IP_B    = 21;
    localparam int REM_QPN_B   = 25;
    localparam int REM_PSN_B   = 29;
    localparam int REM_RKEY_B  = 33;
    localparam int REM_ADDR_B  = 37;
    localparam int REM_IP_B    = 45;
    localparam int LST_PORT_B  = 49;

    conn_mgr_pkg::qp_info_t unpacked;
    logic                   req_valid;
    logic                   msg_xfer;

    assign req_valid = msg[0]; // Byte 0 bit 0 marks a real request

    always_comb begin
        unpacked.req_type       = msg[7:1];
        unpacked.loc_qpn        = msg[8*LOC_QPN_B  +: $bits(conn_mgr_pkg::qpn_t)];
        unpacked.loc_psn        = msg[8*LOC_PSN_B  +: $bits(conn_mgr_pkg::psn_t)];
        unpacked.loc_r_key      = msg[8*LOC_RKEY_B +: $bits(conn_mgr_pkg::r_key_t)];
        unpacked.loc_base_addr  = msg[8*LOC_ADDR_B +: $bits(conn_mgr_pkg::vaddr_t)];
        unpacked.loc_ip_addr    = msg[8*LOC_IP_B   +: $bits(conn_mgr_pkg::ipv4_addr_t)];
        unpacked.rem_qpn        = msg[8*REM_QPN_B  +: $bits(conn_mgr_pkg::qpn_t)];
        unpacked.rem_psn        = msg[8*REM_PSN_B  +: $bits(conn_mgr_pkg::psn_t)];
        unpacked.rem_r_key      = msg[8*REM_RKEY_B +: $bits(conn_mgr_pkg::r_key_t)];
        unpacked.rem_base_addr  = msg[8*REM_ADDR_B +: $bits(conn_mgr_pkg::vaddr_t)];
        unpacked.rem_ip_addr    = msg[8*REM_IP_B   +: $bits(conn_mgr_pkg::ipv4_addr_t)];
        unpacked.listening_port = msg[8*LST_PORT_B +: $bits(conn_mgr_pkg::udp_port_t)];
    end

    // Accept when the output slot is empty or is being emptied this cycle
    assign msg_ready = !qp_info_valid || qp_info_ready;
    assign msg_xfer  = msg_valid && msg_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            qp_info_valid <= 1'b0;
        end else if (msg_xfer) begin
            qp_info_valid <= req_valid; // Requests without the valid bit produce nothing
        end else if (qp_info_ready) begin
            qp_info_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (msg_xfer && req_valid) begin
            qp_info <= unpacked;
        end
    end

endmodule

// File: source/udp_qp_conn_rx.sv
`timescale 1ns/1ps

module udp_qp_conn_rx (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        hdr_valid,
    output logic                        hdr_ready,
    input  conn_mgr_pkg::udp_hdr_t      hdr,
    input  logic                        payload_valid,
    output logic                        payload_ready,
    input  conn_mgr_pkg::payload_beat_t payload,
    output logic                        qp_info_valid,
    input  logic                        qp_info_ready,
    output conn_mgr_pkg::qp_info_t      qp_info,
    output logic                        busy
);

    // Filter to assembler
    logic                        beat_valid;
    logic                        beat_ready;
    conn_mgr_pkg::payload_beat_t beat;

    // Assembler to unpacker
    logic                        msg_valid;
    logic                        msg_ready;
    conn_mgr_pkg::qp_msg_t       msg;

    udp_frame_filter udp_frame_filter_i (
        .clk           (clk),
        .rst           (rst),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .hdr           (hdr),
        .payload_valid (payload_valid),
        .payload_ready (payload_ready),
        .payload       (payload),
        .beat_valid    (beat_valid),
        .beat_ready    (beat_ready),
        .beat          (beat),
        .busy          (busy)
    );

    qp_msg_assembler qp_msg_assembler_i (
        .clk        (clk),
        .rst        (rst),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .beat       (beat),
        .msg_valid  (msg_valid),
        .msg_ready  (msg_ready),
        .msg        (msg)
    );

    // Holds one record, so with the assembler two messages can be in flight
    qp_info_unpack qp_info_unpack_i (
        .clk           (clk),
        .rst           (rst),
        .msg_valid     (msg_valid),
        .msg_ready     (msg_ready),
        .msg           (msg),
        .qp_info_valid (qp_info_valid),
        .qp_info_ready (qp_info_ready),
        .qp_info       (qp_info)
    );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    localparam realtime HALF_PERIOD = 2.0; // 4 ns clock

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: tb/tb_udp_qp_conn_rx.sv
`timescale 1ns/1ps
`include "conn_mgr_settings.svh"

module tb_udp_qp_conn_rx;

    localparam int CLK_PERIOD    = 4;
    localparam int NUM_FRAMES    = 13; // Frames sent over all tests
    localparam int READY_TIMEOUT = 100;
    localparam int FRAME_LEN     = `CM_UDP_HDR_BYTES + `CM_MSG_BYTES;

    logic                        clk;
    logic                        rst;
    logic                        hdr_valid;
    logic                        hdr_ready;
    conn_mgr_pkg::udp_hdr_t      hdr;
    logic                        payload_valid;
    logic                        payload_ready;
    conn_mgr_pkg::payload_beat_t payload;
    logic                        qp_info_valid;
    logic                        qp_info_ready;
    conn_mgr_pkg::qp_info_t      qp_info;
    logic                        busy;

    int                     errors = 0;
    logic [31:0]            lfsr_state = 32'heb882ecb;
    conn_mgr_pkg::qp_info_t rec_q[$]; // Records seen leaving the DUT

    tb_clk_gen tb_clk_gen_i (.clk(clk));

    udp_qp_conn_rx udp_qp_conn_rx_i (
        .clk           (clk),
        .rst           (rst),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .hdr           (hdr),
        .payload_valid (payload_valid),
        .payload_ready (payload_ready),
        .payload       (payload),
        .qp_info_valid (qp_info_valid),
        .qp_info_ready (qp_info_ready),
        .qp_info       (qp_info),
        .busy          (busy)
    );

    // Inputs change 1 ns after the edge, so the falling edge sees settled values
    always @(negedge clk) begin
        if (!rst && qp_info_valid && qp_info_ready) begin
            rec_q.push_back(qp_info);
        end
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic conn_mgr_pkg::qp_msg_t random_msg(input logic valid_bit);
        conn_mgr_pkg::qp_msg_t m;
        for (int i = 0; i < `CM_MSG_BYTES * 8; i++) begin
            m[i] = lfsr_bit();
        end
        m[0] = valid_bit; // Request valid flag
        return m;
    endfunction

    // Little-endian field starting at byte first
    function automatic logic [63:0] field_bytes(input conn_mgr_pkg::qp_msg_t m,
                                                input int first, input int count);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < count; k++) begin
            v[8*k +: 8] = m[8*(first + k) +: 8];
        end
        return v;
    endfunction

    function automatic conn_mgr_pkg::qp_msg_t apply_keep(input conn_mgr_pkg::qp_msg_t m,
                                                         input logic [63:0] mask);
        conn_mgr_pkg::qp_msg_t r;
        r = m;
        for (int i = 0; i < `CM_MSG_BYTES; i++) begin
            if (!mask[i]) r[8*i +: 8] = 8'h00;
        end
        return r;
    endfunction

    function automatic conn_mgr_pkg::qp_info_t expected_record(input conn_mgr_pkg::qp_msg_t m);
        conn_mgr_pkg::qp_info_t r;
        r.req_type       = m[7:1];
        r.loc_qpn        = conn_mgr_pkg::qpn_t'(field_bytes(m, 1, 3));
        r.loc_psn        = conn_mgr_pkg::psn_t'(field_bytes(m, 5, 3));
        r.loc_r_key      = conn_mgr_pkg::r_key_t'(field_bytes(m, 9, 4));
        r.loc_base_addr  = field_bytes(m, 13, 8);
        r.loc_ip_addr    = conn_mgr_pkg::ipv4_addr_t'(field_bytes(m, 21, 4));
        r.rem_qpn        = conn_mgr_pkg::qpn_t'(field_bytes(m, 25, 3));
        r.rem_psn        = conn_mgr_pkg::psn_t'(field_bytes(m, 29, 3));
        r.rem_r_key      = conn_mgr_pkg::r_key_t'(field_bytes(m, 33, 4));
        r.rem_base_addr  = field_bytes(m, 37, 8);
        r.rem_ip_addr    = conn_mgr_pkg::ipv4_addr_t'(field_bytes(m, 45, 4));
        r.listening_port = conn_mgr_pkg::udp_port_t'(field_bytes(m, 49, 2));
        return r;
    endfunction

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_record(input conn_mgr_pkg::qp_info_t got,
                                input conn_mgr_pkg::qp_info_t exp);
        check_value("qp_info.req_type", got.req_type, exp.req_type);
        check_value("qp_info.loc_qpn", got.loc_qpn, exp.loc_qpn);
        check_value("qp_info.loc_psn", got.loc_psn, exp.loc_psn);
        check_value("qp_info.loc_r_key", got.loc_r_key, exp.loc_r_key);
        check_value("qp_info.loc_base_addr", got.loc_base_addr, exp.loc_base_addr);
        check_value("qp_info.loc_ip_addr", got.loc_ip_addr, exp.loc_ip_addr);
        check_value("qp_info.rem_qpn", got.rem_qpn, exp.rem_qpn);
        check_value("qp_info.rem_psn", got.rem_psn, exp.rem_psn);
        check_value("qp_info.rem_r_key", got.rem_r_key, exp.rem_r_key);
        check_value("qp_info.rem_base_addr", got.rem_base_addr, exp.rem_base_addr);
        check_value("qp_info.rem_ip_addr", got.rem_ip_addr, exp.rem_ip_addr);
        check_value("qp_info.listening_port", got.listening_port, exp.listening_port);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_records(input int n);
        int cnt;
        cnt = 0;
        while (rec_q.size() < n && cnt < 200) begin
            idle_cycles(1);
            cnt++;
        end
        if (rec_q.size() != n) begin
            errors++;
            $display("Expected %0d records but %0d arrived", n, rec_q.size());
        end
    endtask

    // Header then num_beats beats, last on the final one; stalls counts cycles without ready
    task automatic send_frame(
        input  conn_mgr_pkg::udp_port_t dest_port,
        input  conn_mgr_pkg::udp_port_t length,
        input  conn_mgr_pkg::qp_msg_t   msg,
        input  logic [63:0]             keep_mask,
        input  int                      num_beats,
        input  int                      user_beat,
        output int                      stalls
    );
        int                          wait_cnt;
        conn_mgr_pkg::payload_beat_t b;
        stalls = 0;
        hdr.source_port = 16'hc350;
        hdr.dest_port   = dest_port;
        hdr.length      = length;
        hdr.checksum    = 16'h0000;
        hdr_valid       = 1'b1;
        wait_cnt        = 0;
        @(negedge clk);
        while (!hdr_ready && wait_cnt < READY_TIMEOUT) begin
            wait_cnt++;
            @(negedge clk);
        end
        if (!hdr_ready) begin
            errors++;
            $display("Timed out waiting for the DUT to take a header");
            hdr_valid = 1'b0;
            return;
        end
        @(posedge clk);
        #1;
        hdr_valid = 1'b0;
        check_value("busy", busy, 1'b1);
        check_value("hdr_ready", hdr_ready, 1'b0); // No new header until the frame ends
        for (int i = 0; i < num_beats; i++) begin
            if (i < `CM_MSG_BEATS) begin
                b.data = msg[i*`CM_DATA_WIDTH +: `CM_DATA_WIDTH];
                b.keep = keep_mask[i*`CM_KEEP_WIDTH +: `CM_KEEP_WIDTH];
            end else begin
                b.data = {8{32'h5a5a_c3c3}}; // Extra beat of an overlong frame
                b.keep = '1;
            end
            b.last        = (i == num_beats - 1);
            b.user        = (i == user_beat);
            payload       = b;
            payload_valid = 1'b1;
            wait_cnt      = 0;
            @(negedge clk);
            while (!payload_ready && wait_cnt < READY_TIMEOUT) begin
                wait_cnt++;
                @(negedge clk);
            end
            stalls += wait_cnt;
            if (!payload_ready) begin
                errors++;
                $display("Timed out waiting for the DUT to take a payload beat");
                payload_valid = 1'b0;
                return;
            end
            @(posedge clk);
            #1;
            payload_valid = 1'b0;
            check_value("busy", busy, (i != num_beats - 1));
        end
    endtask

    task automatic expect_no_record();
        idle_cycles(10);
        if (rec_q.size() != 0) begin
            errors++;
            $display("A record came out for a frame that should have been dropped");
        end
    endtask

    task automatic decode_valid_message();
        conn_mgr_pkg::qp_msg_t  m;
        conn_mgr_pkg::qp_info_t exp;
        int                     stalls;
        rec_q.delete();
        m   = random_msg(1'b1);
        exp = expected_record(m);
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, m, '1, 2, -1, stalls);
        // Assembler register first, then the output register one edge later
        check_value("qp_info_valid", qp_info_valid, 1'b0);
        idle_cycles(1);
        check_value("qp_info_valid", qp_info_valid, 1'b1);
        check_record(qp_info, exp);
        idle_cycles(1);
        check_value("qp_info_valid", qp_info_valid, 1'b0);
        idle_cycles(5);
        check_value("record count", rec_q.size(), 1);
        if (rec_q.size() > 0) check_record(rec_q[0], exp);
    endtask

    task automatic discard_wrong_header();
        int stalls;
        rec_q.delete();
        send_frame(16'h1234, FRAME_LEN, random_msg(1'b1), '1, 2, -1, stalls);
        if (stalls != 0) begin
            errors++;
            $display("payload_ready dropped while a wrong-port frame was discarded");
        end
        send_frame(`CM_LISTEN_PORT, FRAME_LEN + 8, random_msg(1'b1), '1, 2, -1, stalls);
        if (stalls != 0) begin
            errors++;
            $display("payload_ready dropped while a wrong-length frame was discarded");
        end
        expect_no_record();
    endtask

    task automatic drop_invalid_request();
        conn_mgr_pkg::qp_msg_t m;
        int                    stalls;
        rec_q.delete();
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, random_msg(1'b0), '1, 2, -1, stalls);
        expect_no_record();
        m = random_msg(1'b1);
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, m, '1, 2, -1, stalls);
        wait_records(1);
        if (rec_q.size() > 0) check_record(rec_q[0], expected_record(m));
    endtask

    task automatic drop_faulty_frames();
        conn_mgr_pkg::qp_msg_t m;
        int                    stalls;
        rec_q.delete();
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, random_msg(1'b1), '1, 2, 0, stalls);
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, random_msg(1'b1), '1, 1, -1, stalls);
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, random_msg(1'b1), '1, 3, -1, stalls);
        expect_no_record();
        m = random_msg(1'b1);
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, m, '1, 2, -1, stalls);
        wait_records(1);
        if (rec_q.size() > 0) check_record(rec_q[0], expected_record(m));
    endtask

    task automatic hold_under_back_pressure();
        conn_mgr_pkg::qp_msg_t  m[3];
        conn_mgr_pkg::qp_info_t exp[3];
        int                     stalls;
        int                     stalls_c;
        rec_q.delete();
        for (int i = 0; i < 3; i++) begin
            m[i]   = random_msg(1'b1);
            exp[i] = expected_record(m[i]);
        end
        qp_info_ready = 1'b0;
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, m[0], '1, 2, -1, stalls);
        idle_cycles(3);
        check_value("qp_info_valid", qp_info_valid, 1'b1);
        check_record(qp_info, exp[0]);
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, m[1], '1, 2, -1, stalls);
        fork
            send_frame(`CM_LISTEN_PORT, FRAME_LEN, m[2], '1, 2, -1, stalls_c);
            begin
                repeat (20) begin
                    @(negedge clk);
                    check_value("qp_info_valid", qp_info_valid, 1'b1);
                    check_record(qp_info, exp[0]);
                end
                check_value("payload_ready", payload_ready, 1'b0);
                @(posedge clk);
                #1;
                qp_info_ready = 1'b1;
            end
        join
        if (stalls_c == 0) begin
            errors++;
            $display("payload_ready never went low during the third frame");
        end
        wait_records(3);
        for (int i = 0; i < 3 && i < rec_q.size(); i++) begin
            check_record(rec_q[i], exp[i]);
        end
    endtask

    task automatic zero_unkept_bytes();
        localparam logic [63:0] KEEP_MASK = 64'h00f0_ff0f_3c33_a5a5; // Byte 0 stays kept
        conn_mgr_pkg::qp_msg_t m;
        int                    stalls;
        rec_q.delete();
        m = random_msg(1'b1);
        send_frame(`CM_LISTEN_PORT, FRAME_LEN, m, KEEP_MASK, 2, -1, stalls);
        wait_records(1);
        if (rec_q.size() > 0) check_record(rec_q[0], expected_record(apply_keep(m, KEEP_MASK)));
    endtask

    initial begin
        #(CLK_PERIOD * (NUM_FRAMES * 200 + 1000));
        $display("Watchdog ran out before the tests finished");
        $display("Errors: %0d", errors + 1);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst           = 1'b1;
        hdr_valid     = 1'b0;
        hdr           = '0;
        payload_valid = 1'b0;
        payload       = '0;
        qp_info_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("busy", busy, 1'b0);
        check_value("qp_info_valid", qp_info_valid, 1'b0);
        check_value("hdr_ready", hdr_ready, 1'b0);
        check_value("payload_ready", payload_ready, 1'b0);
        idle_cycles(2);
        decode_valid_message();
        discard_wrong_header();
        drop_invalid_request();
        drop_faulty_frames();
        hold_under_back_pressure();
        zero_unkept_bytes();
        idle_cycles(5);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+source
source/conn_mgr_pkg.sv
source/udp_frame_filter.sv
source/qp_msg_assembler.sv
source/qp_info_unpack.sv
source/udp_qp_conn_rx.sv
tb/tb_clk_gen.sv
tb/tb_udp_qp_conn_rx.sv
